//--- bench/core_tests.txt
# columns: name, instruction word count, store count, then the instruction words in hex,
# then one hex address and data pair per expected store, in store order
# add sub and or xor slt chained back to back, then one store per result
alu_chain 15 6
00c00093 00500113 002081b3 40118233 003272b3 0042e333 003343b3 00722433
04302023 04402223 04502423 04602623 04702823 04802a23 0000006f
00000040 00000011
00000044 00000005
00000048 00000001
0000004c 00000005
00000050 00000014
00000054 00000001
# addi -7 and -2048 with dependent stores and signed slt
addi_neg 9 4
ff900093 06102023 80008113 001121b3 06202223 06302423 0020a233 06402623
0000006f
00000060 fffffff9
00000064 fffff7f9
00000068 00000001
0000006c 00000000
# sw then lw, each load feeding the very next instruction
load_use 8 3
12300093 08102023 08002103 08202223 08402183 00318233 08402423 0000006f
00000080 00000123
00000084 00000123
00000088 00000246
# taken beq and jal x5 over shadow stores, link store, beq not taken
branch_jump 11 2
00300093 00300113 00208663 0a102023 0a202223 008002ef 0a102423 0a502823
00008463 0a202a23 0000006f
000000b0 00000018
000000b4 00000003

//--- bench/tb_rv_core.sv
`include "rv_core_cfg.svh"

module tb_rv_core import rv_core_pkg::*;;

	logic clock = 1'b0;
	logic reset = 1'b0;
	logic mem_ready = 1'b1;
	word_t pc, instr, data_addr, data_wdata, data_rdata;
	logic data_read, data_write;

	// instruction and data memories, 256 words each
	word_t imem [256];
	word_t dmem [256];

	// parsed test file
	string names [16];
	int word_base [16];
	int word_cnt [16];
	int store_base [16];
	int store_cnt [16];
	word_t words [512];
	word_t exp_addr [128];
	word_t exp_data [128];
	int test_count = 0;
	int total_words = 0;
	int total_stores = 0;
	logic parse_error = 1'b0;

	// run state
	int cur = 0;
	int seen = 0;
	int limit_cycles = 0;
	logic running = 1'b0;
	logic random_ready = 1'b0;
	integer seed = 32'h83ee;
	logic [31:0] rnd;

	always #4 clock = ~clock;

	rv_core UUT (
		.clock(clock), .reset(reset), .pc(pc), .instr(instr),
		.data_addr(data_addr), .data_read(data_read), .data_write(data_write),
		.data_wdata(data_wdata), .data_rdata(data_rdata), .mem_ready(mem_ready)
	);

	// both memories answer in the same cycle
	assign instr = imem[pc[9:2]];

	// read data only valid on an accepted read
	assign data_rdata = (data_read && mem_ready) ? dmem[data_addr[9:2]] : 32'hbad0_bad0;

	// wait states, about one cycle in four
	always @(negedge clock) begin
		rnd = $random(seed);
		mem_ready <= random_ready ? (rnd[1:0] != 2'b00) : 1'b1;
	end

	task automatic check_value(input string what, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("ERROR test %s (%s): %s expected %h, actual %h", names[cur],
				random_ready ? "random ready" : "ready high", what, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////
	// store checker
	//////////////////////////////////////////////////
	always @(posedge clock) begin : store_monitor
		int i;
		if (!running) begin
			seen <= 0;
			for (i = 0; i < 256; i++) begin
				dmem[i] <= 32'hd0d0_0000 ^ (i * 32'h0001_0003);
			end
		end else if (data_write && mem_ready) begin
			if (seen >= store_cnt[cur]) begin
				$display("test %s made an unexpected store of %h to %h", names[cur],
					data_wdata, data_addr);
				$display("TESTS FAILED");
				$fatal(1);
			end else begin
				check_value("store address", exp_addr[store_base[cur] + seen], data_addr);
				check_value("store data", exp_data[store_base[cur] + seen], data_wdata);
				dmem[data_addr[9:2]] <= data_wdata;
				seen <= seen + 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// test file reader
	//////////////////////////////////////////////////
	task automatic read_tests(input int fd);
		int code, c, nw, ns, k;
		string tok;
		word_t w, a, d;
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok[0] == "#") begin
				// comment, drop the rest of the line
				c = $fgetc(fd);
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end else begin
				nw = 0;
				ns = 0;
				if ($fscanf(fd, "%d %d", nw, ns) != 2) begin
					parse_error = 1'b1;
				end
				names[test_count] = tok;
				word_base[test_count] = total_words;
				word_cnt[test_count] = nw;
				store_base[test_count] = total_stores;
				store_cnt[test_count] = ns;
				for (k = 0; k < nw; k++) begin
					if ($fscanf(fd, "%h", w) != 1) begin
						parse_error = 1'b1;
					end
					words[total_words] = w;
					total_words++;
				end
				for (k = 0; k < ns; k++) begin
					if ($fscanf(fd, "%h %h", a, d) != 2) begin
						parse_error = 1'b1;
					end
					exp_addr[total_stores] = a;
					exp_data[total_stores] = d;
					total_stores++;
				end
				test_count++;
			end
			code = $fscanf(fd, "%s", tok);
		end
	endtask

	// one program from reset until its last expected store
	task automatic run_test(input int t, input logic random_mode);
		int i;
		@(negedge clock);
		reset = 1'b0;
		running = 1'b0;
		cur = t;
		random_ready = random_mode;
		for (i = 0; i < 256; i++) begin
			imem[i] = `NOP_INSTR;
		end
		for (i = 0; i < word_cnt[t]; i++) begin
			imem[`RESET_PC / 4 + i] = words[word_base[t] + i];
		end
		repeat (8) @(negedge clock);
		// state held by reset
		check_value("reset pc", `RESET_PC, pc);
		check_value("reset data_read", word_t'(0), word_t'(data_read));
		check_value("reset data_write", word_t'(0), word_t'(data_write));
		running = 1'b1;
		reset = 1'b1;
		while (seen < store_cnt[t]) begin
			@(negedge clock);
		end
		// quiet window, a skipped store showing up late still fails
		repeat (10) @(negedge clock);
		running = 1'b0;
	endtask

	initial begin : test_sequence
		int fd, run, t;
		fd = $fopen("bench/core_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/core_tests.txt");
			$display("TESTS FAILED");
			$fatal(1);
		end else begin
			read_tests(fd);
			$fclose(fd);
			if (parse_error || test_count == 0) begin
				$display("the test file is empty or malformed");
				$display("TESTS FAILED");
				$fatal(1);
			end else begin
				// every program runs twice, ready held high and then random
				limit_cycles = 2 * (40 * total_words + 18 * test_count);
				for (run = 0; run < 2; run++) begin
					for (t = 0; t < test_count; t++) begin
						run_test(t, run == 1);
					end
				end
				$display("TESTS PASSED");
				$finish;
			end
		end
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout after %0d cycles, the core stopped storing in test %s",
			limit_cycles, names[cur]);
		$display("TESTS FAILED");
		$fatal(1);
	end

endmodule

//--- build.f
+incdir+logic
logic/rv_core_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
bench/tb_rv_core.sv

//--- logic/decode_stage.sv
module decode_stage import rv_core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      stall,
	input  logic      freeze,
	input  logic      flush_ex,
	input  word_t     if_pc,
	input  word_t     if_instr,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	input  word_t     rs1_data,
	input  word_t     rs2_data,
	output logic      id_jump,
	output word_t     jump_target,
	output alu_op_e   ex_alu_op,
	output logic      ex_use_imm,
	output logic      ex_mem_read,
	output logic      ex_mem_write,
	output logic      ex_branch,
	output logic      ex_reg_write,
	output wb_sel_e   ex_wb_sel,
	output reg_addr_t ex_rs1,
	output reg_addr_t ex_rs2,
	output reg_addr_t ex_rd,
	output word_t     ex_pc,
	output word_t     ex_rs1_data,
	output word_t     ex_rs2_data,
	output word_t     ex_imm
);

	opcode_e opcode;
	reg_addr_t rd;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_j, imm;
	alu_op_e alu_op;
	logic use_imm, mem_read, mem_write, branch, reg_write;
	wb_sel_e wb_sel;

	assign opcode = opcode_e'(if_instr[6:0]);
	assign rd = if_instr[11:7];
	assign funct3 = if_instr[14:12];
	assign rs1 = if_instr[19:15];
	assign rs2 = if_instr[24:20];
	assign funct7 = if_instr[31:25];

	// immediates, all sign extended from bit 31
	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	//////////////////////////////////////////////////
	// main control
	//////////////////////////////////////////////////
	always_comb begin
		alu_op = alu_add;
		use_imm = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		reg_write = 1'b0;
		wb_sel = wb_alu;
		imm = imm_i;
		case (opcode)
			op_reg: begin
				reg_write = 1'b1;
				case (funct3)
					f3_add_sub: alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
					f3_slt: alu_op = alu_slt;
					f3_xor: alu_op = alu_xor;
					f3_or: alu_op = alu_or;
					f3_and: alu_op = alu_and;
					default: alu_op = alu_add;
				endcase
			end
			op_imm: begin
				reg_write = 1'b1;
				use_imm = 1'b1;
			end
			op_load: begin
				reg_write = 1'b1;
				use_imm = 1'b1;
				mem_read = 1'b1;
				wb_sel = wb_mem;
			end
			op_store: begin
				use_imm = 1'b1;
				mem_write = 1'b1;
				imm = imm_s;
			end
			op_branch: begin
				branch = 1'b1;
				imm = imm_b;
			end
			op_jal: begin
				reg_write = 1'b1;
				wb_sel = wb_link;
				imm = imm_j;
			end
			default: ;
		endcase
	end

	// jal redirects from here, one slot early
	assign id_jump = (opcode == op_jal);
	assign jump_target = if_pc + imm_j;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_alu_op <= alu_add;
			ex_use_imm <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_wb_sel <= wb_alu;
			ex_rs1 <= '0;
			ex_rs2 <= '0;
			ex_rd <= '0;
		end else if (!freeze) begin
			if (stall || flush_ex) begin
				ex_alu_op <= alu_add;
				ex_use_imm <= 1'b0;
				ex_mem_read <= 1'b0;
				ex_mem_write <= 1'b0;
				ex_branch <= 1'b0;
				ex_reg_write <= 1'b0;
				ex_wb_sel <= wb_alu;
				ex_rs1 <= '0;
				ex_rs2 <= '0;
				ex_rd <= '0;
			end else begin
				ex_alu_op <= alu_op;
				ex_use_imm <= use_imm;
				ex_mem_read <= mem_read;
				ex_mem_write <= mem_write;
				ex_branch <= branch;
				// writes to x0 are dropped here
				ex_reg_write <= reg_write && (rd != '0);
				ex_wb_sel <= wb_sel;
				ex_rs1 <= rs1;
				ex_rs2 <= rs2;
				ex_rd <= rd;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			ex_pc <= if_pc;
			ex_rs1_data <= rs1_data;
			ex_rs2_data <= rs2_data;
			ex_imm <= imm;
		end
	end

endmodule

//--- logic/execute_stage.sv
module execute_stage import rv_core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      freeze,
	input  alu_op_e   ex_alu_op,
	input  logic      ex_use_imm,
	input  logic      ex_mem_read,
	input  logic      ex_mem_write,
	input  logic      ex_branch,
	input  logic      ex_reg_write,
	input  wb_sel_e   ex_wb_sel,
	input  reg_addr_t ex_rs1,
	input  reg_addr_t ex_rs2,
	input  reg_addr_t ex_rd,
	input  word_t     ex_pc,
	input  word_t     ex_rs1_data,
	input  word_t     ex_rs2_data,
	input  word_t     ex_imm,
	input  logic      wb_we,
	input  reg_addr_t wb_rd,
	input  word_t     wb_data,
	output logic      ex_branch_taken,
	output word_t     branch_target,
	output word_t     mem_alu_out,
	output word_t     mem_store_data,
	output word_t     mem_link,
	output reg_addr_t mem_rd,
	output logic      mem_reg_write,
	output logic      mem_read,
	output logic      mem_write,
	output wb_sel_e   mem_wb_sel
);

	logic mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;
	word_t mem_fwd, op_a, op_b, alu_b, alu_out;

	//////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////

	// a jal one stage ahead forwards its link, not the ALU result
	assign mem_fwd = (mem_wb_sel == wb_link) ? mem_link : mem_alu_out;

	assign mem_hit_a = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs1);
	assign mem_hit_b = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs2);
	assign wb_hit_a = wb_we && (wb_rd != '0) && (wb_rd == ex_rs1);
	assign wb_hit_b = wb_we && (wb_rd != '0) && (wb_rd == ex_rs2);

	// nearest producer first
	assign op_a = mem_hit_a ? mem_fwd : (wb_hit_a ? wb_data : ex_rs1_data);
	assign op_b = mem_hit_b ? mem_fwd : (wb_hit_b ? wb_data : ex_rs2_data);

	assign alu_b = ex_use_imm ? ex_imm : op_b;

	always_comb begin
		case (ex_alu_op)
			alu_add: alu_out = op_a + alu_b;
			alu_sub: alu_out = op_a - alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_or: alu_out = op_a | alu_b;
			alu_xor: alu_out = op_a ^ alu_b;
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(alu_b));
			default: alu_out = op_a + alu_b;
		endcase
	end

	// beq only
	assign ex_branch_taken = ex_branch && (op_a == op_b);
	assign branch_target = ex_pc + ex_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_rd <= '0;
			mem_reg_write <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_wb_sel <= wb_alu;
		end else if (!freeze) begin
			mem_rd <= ex_rd;
			mem_reg_write <= ex_reg_write;
			mem_read <= ex_mem_read;
			mem_write <= ex_mem_write;
			mem_wb_sel <= ex_wb_sel;
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			mem_alu_out <= alu_out;
			mem_store_data <= op_b;
			mem_link <= ex_pc + word_t'(4);
		end
	end

endmodule

//--- logic/fetch_stage.sv
`include "rv_core_cfg.svh"

module fetch_stage import rv_core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  stall,
	input  logic  freeze,
	input  logic  flush_id,
	input  logic  id_jump,
	input  logic  ex_branch_taken,
	input  word_t jump_target,
	input  word_t branch_target,
	input  word_t instr,
	output word_t pc,
	output word_t if_pc,
	output word_t if_instr
);

	word_t next_pc;

	// older redirect wins, the branch sits one stage further on
	always_comb begin
		if (ex_branch_taken) begin
			next_pc = branch_target;
		end else if (id_jump) begin
			next_pc = jump_target;
		end else begin
			next_pc = pc + word_t'(4);
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= `RESET_PC;
			if_instr <= `NOP_INSTR;
		end else if (!freeze && !stall) begin
			pc <= next_pc;
			if_instr <= flush_id ? `NOP_INSTR : instr;
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze && !stall) begin
			if_pc <= pc;
		end
	end

endmodule

//--- logic/hazard_unit.sv
module hazard_unit import rv_core_pkg::*; (
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  reg_addr_t ex_rd,
	input  logic      ex_mem_read,
	input  logic      id_jump,
	input  logic      ex_branch_taken,
	input  logic      data_read,
	input  logic      data_write,
	input  logic      mem_ready,
	output logic      stall,
	output logic      flush_id,
	output logic      flush_ex,
	output logic      freeze
);

	logic load_use;
	logic access_wait;

	// load in execute feeding the instruction in decode
	assign load_use = ex_mem_read && (ex_rd != '0) && ((ex_rd == rs1) || (ex_rd == rs2));

	assign access_wait = (data_read || data_write) && !mem_ready;

	//////////////////////////////////////////////////
	// pipeline control
	//////////////////////////////////////////////////
	always_comb begin
		freeze = access_wait;

		// a taken branch squashes decode, so no need to stall it
		stall = !freeze && !ex_branch_taken && load_use;

		// a stalled jal stays put and redirects one cycle later
		flush_id = !freeze && (ex_branch_taken || (id_jump && !stall));
		flush_ex = !freeze && ex_branch_taken;
	end

endmodule

//--- logic/mem_wb_stage.sv
module mem_wb_stage import rv_core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      freeze,
	input  word_t     mem_alu_out,
	input  word_t     mem_store_data,
	input  word_t     mem_link,
	input  reg_addr_t mem_rd,
	input  logic      mem_reg_write,
	input  logic      mem_read,
	input  logic      mem_write,
	input  wb_sel_e   mem_wb_sel,
	input  word_t     data_rdata,
	output word_t     data_addr,
	output word_t     data_wdata,
	output logic      data_read,
	output logic      data_write,
	output logic      wb_we,
	output reg_addr_t wb_rd,
	output word_t     wb_data
);

	wb_sel_e wb_sel;
	word_t wb_alu_out, wb_load, wb_link_val;

	// straight from EX/MEM, so a held register keeps the port steady
	assign data_addr = mem_alu_out;
	assign data_wdata = mem_store_data;
	assign data_read = mem_read;
	assign data_write = mem_write;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_we <= 1'b0;
			wb_rd <= '0;
			wb_sel <= wb_alu;
		end else if (!freeze) begin
			wb_we <= mem_reg_write;
			wb_rd <= mem_rd;
			wb_sel <= mem_wb_sel;
		end
	end

	// load data is captured on the accepting edge
	always_ff @(posedge clock) begin
		if (!freeze) begin
			wb_alu_out <= mem_alu_out;
			wb_load <= data_rdata;
			wb_link_val <= mem_link;
		end
	end

	always_comb begin
		case (wb_sel)
			wb_mem: wb_data = wb_load;
			wb_link: wb_data = wb_link_val;
			default: wb_data = wb_alu_out;
		endcase
	end

	a_one_access: assert property (@(posedge clock) disable iff (!reset)
		!(data_read && data_write));

endmodule

//--- logic/register_file.sv
`include "rv_core_cfg.svh"

module register_file (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [$clog2(`REG_COUNT)-1:0] rs1,
	input  logic [$clog2(`REG_COUNT)-1:0] rs2,
	input  logic [$clog2(`REG_COUNT)-1:0] wb_rd,
	input  logic                             wb_we,
	input  logic [`XLEN-1:0]                 wb_data,
	output logic [`XLEN-1:0]                 rs1_data,
	output logic [`XLEN-1:0]                 rs2_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we && (wb_rd != '0)) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// same-cycle write shows through to decode
	assign rs1_data = (wb_we && (wb_rd != '0) && (wb_rd == rs1)) ? wb_data : regs[rs1];
	assign rs2_data = (wb_we && (wb_rd != '0) && (wb_rd == rs2)) ? wb_data : regs[rs2];

	// decode drops the write enable for rd = x0, so a jal link never lands here
	a_x0_clean: assert property (@(posedge clock) disable iff (!reset)
		(wb_we && (wb_rd == '0)) |-> (wb_data == '0));

endmodule

//--- logic/rv_core.sv
module rv_core import rv_core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	output word_t pc,
	input  word_t instr,
	output word_t data_addr,
	output logic  data_read,
	output logic  data_write,
	output word_t data_wdata,
	input  word_t data_rdata,
	input  logic  mem_ready
);

	// fetch to decode
	word_t if_pc, if_instr;
	logic id_jump;
	word_t jump_target;

	// decode and register file
	reg_addr_t rs1, rs2;
	word_t rs1_data, rs2_data;

	// ID/EX
	alu_op_e ex_alu_op;
	logic ex_use_imm, ex_mem_read, ex_mem_write, ex_branch, ex_reg_write;
	wb_sel_e ex_wb_sel;
	reg_addr_t ex_rs1, ex_rs2, ex_rd;
	word_t ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;

	// execute results and EX/MEM
	logic ex_branch_taken;
	word_t branch_target;
	word_t mem_alu_out, mem_store_data, mem_link;
	reg_addr_t mem_rd;
	logic mem_reg_write, mem_read, mem_write;
	wb_sel_e mem_wb_sel;

	// write-back
	logic wb_we;
	reg_addr_t wb_rd;
	word_t wb_data;

	// hazard control
	logic stall, flush_id, flush_ex, freeze;

	//////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////
	fetch_stage u_fetch (
		.clock(clock), .reset(reset), .stall(stall), .freeze(freeze),
		.flush_id(flush_id), .id_jump(id_jump), .ex_branch_taken(ex_branch_taken),
		.jump_target(jump_target), .branch_target(branch_target), .instr(instr),
		.pc(pc), .if_pc(if_pc), .if_instr(if_instr)
	);

	decode_stage u_decode (
		.clock(clock), .reset(reset), .stall(stall), .freeze(freeze),
		.flush_ex(flush_ex), .if_pc(if_pc), .if_instr(if_instr),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.id_jump(id_jump), .jump_target(jump_target),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_branch(ex_branch), .ex_reg_write(ex_reg_write),
		.ex_wb_sel(ex_wb_sel), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
		.ex_imm(ex_imm)
	);

	register_file u_regs (
		.clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .wb_rd(wb_rd),
		.wb_we(wb_we), .wb_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	hazard_unit u_hazard (
		.rs1(rs1), .rs2(rs2), .ex_rd(ex_rd), .ex_mem_read(ex_mem_read),
		.id_jump(id_jump), .ex_branch_taken(ex_branch_taken),
		.data_read(data_read), .data_write(data_write), .mem_ready(mem_ready),
		.stall(stall), .flush_id(flush_id), .flush_ex(flush_ex), .freeze(freeze)
	);

	execute_stage u_execute (
		.clock(clock), .reset(reset), .freeze(freeze),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_branch(ex_branch), .ex_reg_write(ex_reg_write),
		.ex_wb_sel(ex_wb_sel), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
		.ex_imm(ex_imm), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.ex_branch_taken(ex_branch_taken), .branch_target(branch_target),
		.mem_alu_out(mem_alu_out), .mem_store_data(mem_store_data), .mem_link(mem_link),
		.mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_read(mem_read),
		.mem_write(mem_write), .mem_wb_sel(mem_wb_sel)
	);

	mem_wb_stage u_mem_wb (
		.clock(clock), .reset(reset), .freeze(freeze),
		.mem_alu_out(mem_alu_out), .mem_store_data(mem_store_data), .mem_link(mem_link),
		.mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_read(mem_read),
		.mem_write(mem_write), .mem_wb_sel(mem_wb_sel), .data_rdata(data_rdata),
		.data_addr(data_addr), .data_wdata(data_wdata), .data_read(data_read),
		.data_write(data_write), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

//--- logic/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

//////////////////////////////////////////////////
// core widths
//////////////////////////////////////////////////

// data and address width
`define XLEN 32

// integer register count, x0 included
`define REG_COUNT 32

//////////////////////////////////////////////////
// reset and bubble values
//////////////////////////////////////////////////

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

//--- logic/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_e;

	// write-back source
	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_mem  = 2'd1,
		wb_link = 2'd2
	} wb_sel_e;

	// funct3 codes of the R-type ops
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7 that turns add into sub
	localparam logic [6:0] f7_sub = 7'b0100000;

endpackage

//--- run.sh
#!/bin/sh
# builds the core testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module tb_rv_core -f build.f \
	--Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
